/* Bender.yml */
package:
  name: soc_fabric

sources:
  - files:
      - logic/fabric_pkg.sv
      - logic/addr_decoder.sv
      - logic/bus_arbiter.sv
      - logic/tcm_target.sv
      - logic/gpio_target.sv
      - logic/fault_capture.sv
      - logic/fabric_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/fabric_tb.sv

/* all.f */
+incdir+include
logic/fabric_pkg.sv
logic/addr_decoder.sv
logic/bus_arbiter.sv
logic/tcm_target.sv
logic/gpio_target.sv
logic/fault_capture.sv
logic/fabric_top.sv
bench/fabric_tb.sv

/* include/fabric_tb_vectors.svh */
`ifndef FABRIC_TB_VECTORS_SVH
`define FABRIC_TB_VECTORS_SVH

// kind, address, size, wdata, gpio_i, expected rdata, expected cause, expected fault address
// a dual step reads the data bus at the address given in the wdata column
task automatic load_table();
    add_step(k_write, 32'h1000_0000, acc_word, 32'h1122_3344, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_write, 32'h1000_0004, acc_word, 32'ha5a5_5a5a, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_read, 32'h1000_0000, acc_word, 32'h0, 8'h00, 32'h1122_3344, fault_none, 32'h0);
    add_step(k_read, 32'h1000_0004, acc_word, 32'h0, 8'h00, 32'ha5a5_5a5a, fault_none, 32'h0);
    // lane merges
    add_step(k_write, 32'h1000_0001, acc_byte, 32'h0000_00ee, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_write, 32'h1000_0006, acc_half, 32'h1234_beef, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_write, 32'h1000_0003, acc_byte, 32'hffff_ff77, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_read, 32'h1000_0000, acc_word, 32'h0, 8'h00, 32'h7722_ee44, fault_none, 32'h0);
    add_step(k_read, 32'h1000_0004, acc_word, 32'h0, 8'h00, 32'hbeef_5a5a, fault_none, 32'h0);
    // index wraps at the depth
    add_step(k_read, 32'h1000_1000, acc_word, 32'h0, 8'h00, 32'h7722_ee44, fault_none, 32'h0);
    // fetches
    add_step(k_write, 32'h1000_0100, acc_word, 32'h0000_0013, 8'h00, 32'h0, fault_none, 32'h0);
    add_step(k_fetch, 32'h1000_0100, acc_word, 32'h0, 8'h00, 32'h0000_0013, fault_none, 32'h0);
    add_step(k_dual, 32'h1000_0000, acc_word, 32'h1000_0004, 8'h00, 32'h7722_ee44,
             fault_none, 32'h0);
    // gpio
    add_step(k_write, 32'h2000_0000, acc_word, 32'h0000_00a5, 8'h3c, 32'h0, fault_none, 32'h0);
    add_step(k_write, 32'h2000_0004, acc_word, 32'h0000_000f, 8'h3c, 32'h0, fault_none, 32'h0);
    add_step(k_write, 32'h2000_0008, acc_word, 32'h0000_00ff, 8'h3c, 32'h0, fault_none, 32'h0);
    add_step(k_read, 32'h2000_0000, acc_word, 32'h0, 8'h3c, 32'h0000_00a5, fault_none, 32'h0);
    add_step(k_read, 32'h2000_0004, acc_word, 32'h0, 8'h3c, 32'h0000_000f, fault_none, 32'h0);
    add_step(k_read, 32'h2000_0008, acc_word, 32'h0, 8'h3c, 32'h0000_003c, fault_none, 32'h0);
    add_step(k_read, 32'h2000_0010, acc_word, 32'h0, 8'h3c, 32'h0, fault_none, 32'h0);
    // misaligned word read and then a gpio read that must stay silent
    add_step(k_dfault, 32'h1000_0002, acc_word, 32'h0, 8'h3c, 32'h0, fault_dbus, 32'h1000_0002);
    add_step(k_dfault, 32'h2000_0000, acc_word, 32'h0, 8'h3c, 32'h0, fault_dbus, 32'h1000_0002);
    add_step(k_reset, 32'h0, acc_word, 32'h0, 8'h3c, 32'h0, fault_none, 32'h0);
    add_step(k_read, 32'h1000_0000, acc_word, 32'h0, 8'h3c, 32'h7722_ee44, fault_none, 32'h0);
    add_step(k_ifault, 32'h2000_0000, acc_word, 32'h0, 8'h3c, 32'h0, fault_ibus, 32'h2000_0000);
endtask

`endif

/* bench/fabric_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_tb import fabric_pkg::*; ();

    localparam int tcm_depth    = 1024;
    localparam int gpio_width   = 8;
    localparam int max_steps    = 32;
    localparam int reset_cycles = 10;
    localparam int resp_wait    = 8;

    // step kinds
    localparam int k_write  = 0;
    localparam int k_read   = 1;
    localparam int k_fetch  = 2;
    localparam int k_dual   = 3;
    localparam int k_reset  = 4;
    localparam int k_dfault = 5;
    localparam int k_ifault = 6;

    logic                  clk, rstn;
    logic [xlen-1:0]       ibus_addr, dbus_addr;
    acc_e                  ibus_acc, dbus_acc;
    logic                  ibus_req, dbus_req, dbus_w_rb;
    logic [bus_width-1:0]  dbus_wdata;
    logic [gpio_width-1:0] gpio_i;
    wire [bus_width-1:0]   ibus_rdata, dbus_rdata;
    wire                   ibus_resp, dbus_resp, fault;
    wire [gpio_width-1:0]  gpio_o, gpio_dir;
    wire fault_cause_e     fault_cause;
    wire [xlen-1:0]        fault_addr;

    int                    step_kind [max_steps];
    logic [xlen-1:0]       step_addr [max_steps];
    acc_e                  step_acc [max_steps];
    logic [bus_width-1:0]  step_wdata [max_steps];
    logic [gpio_width-1:0] step_gpio [max_steps];
    logic [bus_width-1:0]  step_rdata [max_steps];
    fault_cause_e          step_cause [max_steps];
    logic [xlen-1:0]       step_faddr [max_steps];
    int                    n_steps;

    // reference model state
    logic [bus_width-1:0]  ref_mem [int];
    logic [gpio_width-1:0] ref_out, ref_dir, ref_in;

    int errors, other_errors, cycle_limit;
    int cycles = 0;

    fabric_top #(
        .tcm_depth  (tcm_depth),
        .gpio_width (gpio_width)
    ) i_fabric_top (
        .clk         (clk),
        .rstn        (rstn),
        .ibus_addr   (ibus_addr),
        .ibus_acc    (ibus_acc),
        .ibus_req    (ibus_req),
        .ibus_rdata  (ibus_rdata),
        .ibus_resp   (ibus_resp),
        .dbus_addr   (dbus_addr),
        .dbus_w_rb   (dbus_w_rb),
        .dbus_acc    (dbus_acc),
        .dbus_wdata  (dbus_wdata),
        .dbus_req    (dbus_req),
        .dbus_rdata  (dbus_rdata),
        .dbus_resp   (dbus_resp),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_dir    (gpio_dir),
        .fault       (fault),
        .fault_cause (fault_cause),
        .fault_addr  (fault_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic add_step(input int kind, input logic [xlen-1:0] addr, input acc_e acc,
                            input logic [bus_width-1:0] wdata,
                            input logic [gpio_width-1:0] gpio,
                            input logic [bus_width-1:0] rdata, input fault_cause_e cause,
                            input logic [xlen-1:0] faddr);
        step_kind[n_steps]  = kind;
        step_addr[n_steps]  = addr;
        step_acc[n_steps]   = acc;
        step_wdata[n_steps] = wdata;
        step_gpio[n_steps]  = gpio;
        step_rdata[n_steps] = rdata;
        step_cause[n_steps] = cause;
        step_faddr[n_steps] = faddr;
        n_steps++;
    endtask

    `include "fabric_tb_vectors.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // narrow writes take the low bits of wdata
    task automatic model_write(input logic [xlen-1:0] addr, input acc_e acc,
                               input logic [bus_width-1:0] wdata);
        int                   idx;
        logic [bus_width-1:0] word;
        idx = int'((addr >> 2) % tcm_depth);
        if ((addr & tcm_sel_mask) == tcm_base) begin
            word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
            case (acc)
                acc_byte: word[8*addr[1:0] +: 8] = wdata[7:0];
                acc_half: word[16*addr[1] +: 16] = wdata[15:0];
                default:  word = wdata;
            endcase
            ref_mem[idx] = word;
        end else if (addr[7:0] == gpio_out_off) begin
            ref_out = wdata[gpio_width-1:0];
        end else if (addr[7:0] == gpio_dir_off) begin
            ref_dir = wdata[gpio_width-1:0];
        end
    endtask

    function automatic logic [bus_width-1:0] model_read(input logic [xlen-1:0] addr);
        int idx;
        idx = int'((addr >> 2) % tcm_depth);
        if ((addr & tcm_sel_mask) == tcm_base) begin
            return ref_mem.exists(idx) ? ref_mem[idx] : '0;
        end
        case (addr[7:0])
            gpio_out_off: return bus_width'(ref_out);
            gpio_dir_off: return bus_width'(ref_dir);
            gpio_in_off:  return bus_width'(ref_in);
            default:      return '0;
        endcase
    endfunction

    task automatic apply_reset();
        ibus_req = 1'b0;
        dbus_req = 1'b0;
        rstn     = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic run_step(input int i);
        logic [bus_width-1:0] ibus_got, dbus_got;
        int                   kind, ibus_lat, dbus_lat, waited;
        bit                   need_i, need_d, faulting, done;
        kind     = step_kind[i];
        need_i   = kind == k_fetch || kind == k_dual;
        need_d   = kind == k_write || kind == k_read || kind == k_dual;
        faulting = kind == k_dfault || kind == k_ifault;
        done     = !faulting && !need_i && !need_d;
        ibus_lat = 0;
        dbus_lat = 0;
        waited   = 0;
        gpio_i   = step_gpio[i];
        if (kind == k_reset) begin
            apply_reset();
            ref_out = '0;
            ref_dir = '0;
        end
        if (need_i || kind == k_ifault) begin
            ibus_addr = step_addr[i];
            ibus_acc  = step_acc[i];
            ibus_req  = 1'b1;
        end
        // dual steps carry the data bus address in the wdata column
        if (kind == k_dual) begin
            dbus_addr = step_wdata[i];
            dbus_acc  = acc_word;
            dbus_w_rb = 1'b0;
            dbus_req  = 1'b1;
        end else if (need_d || kind == k_dfault) begin
            dbus_addr  = step_addr[i];
            dbus_acc   = step_acc[i];
            dbus_wdata = step_wdata[i];
            dbus_w_rb  = kind == k_write;
            dbus_req   = 1'b1;
        end
        while (waited < resp_wait && !done) begin
            @(negedge clk);
            ibus_req = 1'b0;
            dbus_req = 1'b0;
            waited++;
            if (ibus_resp && ibus_lat == 0) begin
                ibus_lat = waited;
                ibus_got = ibus_rdata;
            end
            if (dbus_resp && dbus_lat == 0) begin
                dbus_lat = waited;
                dbus_got = dbus_rdata;
            end
            done = !faulting && (!need_i || ibus_lat > 0) && (!need_d || dbus_lat > 0);
        end
        if (faulting && (ibus_lat > 0 || dbus_lat > 0)) begin
            $display("step %0d: a response came back for an access that should fault", i);
            other_errors++;
        end
        if (!faulting && !done) begin
            $display("step %0d: no response within %0d cycles", i, resp_wait);
            other_errors++;
        end else begin
            if (need_d)
                check_value("dbus_resp latency", dbus_lat, 1);
            if (need_i)
                check_value("ibus_resp latency", ibus_lat, kind == k_dual ? 2 : 1);
            if (kind == k_read || need_i)
                check_value("table rdata", step_rdata[i], model_read(step_addr[i]));
            if (kind == k_read)
                check_value("dbus_rdata", dbus_got, step_rdata[i]);
            if (need_i)
                check_value("ibus_rdata", ibus_got, step_rdata[i]);
            if (kind == k_dual)
                check_value("dbus_rdata", dbus_got, model_read(step_wdata[i]));
            if (kind == k_write)
                model_write(step_addr[i], step_acc[i], step_wdata[i]);
        end
        check_value("fault", fault, step_cause[i] != fault_none);
        check_value("fault_cause", fault_cause, step_cause[i]);
        check_value("fault_addr", fault_addr, step_faddr[i]);
        check_value("gpio_o", gpio_o, ref_out);
        check_value("gpio_dir", gpio_dir, ref_dir);
        // idle gap lets gpio_i pass the synchronizer
        ref_in = step_gpio[i];
        repeat (2) @(negedge clk);
    endtask

    initial begin
        rstn         = 1'b0;
        ibus_addr    = '0;
        ibus_acc     = acc_word;
        ibus_req     = 1'b0;
        dbus_addr    = '0;
        dbus_w_rb    = 1'b0;
        dbus_acc     = acc_word;
        dbus_wdata   = '0;
        dbus_req     = 1'b0;
        gpio_i       = '0;
        ref_out      = '0;
        ref_dir      = '0;
        ref_in       = '0;
        errors       = 0;
        other_errors = 0;
        n_steps      = 0;
        load_table();
        cycle_limit = 40 * n_steps + reset_cycles;
        apply_reset();
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        $display("%0d value errors, %0d other errors", errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder import fabric_pkg::*; (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [xlen-1:0]       ibus_addr,
    input  wire                  ibus_req,
    input  wire [xlen-1:0]       dbus_addr,
    input  wire                  dbus_req,
    input  wire                  fault,
    input  wire [bus_width-1:0]  ibus_tcm_rdata,
    input  wire                  ibus_tcm_resp,
    input  wire [bus_width-1:0]  dbus_tcm_rdata,
    input  wire                  dbus_tcm_resp,
    input  wire [bus_width-1:0]  dbus_gpio_rdata,
    input  wire                  dbus_gpio_resp,
    output logic                 ibus_tcm_req,
    output logic                 dbus_tcm_req,
    output logic                 dbus_gpio_req,
    output logic [bus_width-1:0] ibus_rdata,
    output logic                 ibus_resp,
    output logic [bus_width-1:0] dbus_rdata,
    output logic                 dbus_resp,
    output logic                 ibus_dec_fault,
    output logic                 dbus_dec_fault
);
    logic ibus_tcm_sel, dbus_tcm_sel, dbus_gpio_sel;
    logic ibus_tcm_rsel, dbus_tcm_rsel, dbus_gpio_rsel;

    assign ibus_tcm_sel  = (ibus_addr & tcm_sel_mask) == tcm_base;
    assign dbus_tcm_sel  = (dbus_addr & tcm_sel_mask) == tcm_base;
    assign dbus_gpio_sel = (dbus_addr & gpio_sel_mask) == gpio_base;

    assign ibus_tcm_req  = ibus_req & ibus_tcm_sel;
    assign dbus_tcm_req  = dbus_req & dbus_tcm_sel;
    assign dbus_gpio_req = dbus_req & dbus_gpio_sel;

    // instruction fetches only reach the tcm
    assign ibus_dec_fault = ibus_req & ~ibus_tcm_sel;
    assign dbus_dec_fault = dbus_req & ~(dbus_tcm_sel | dbus_gpio_sel);

    // selects follow the last request on each bus
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_tcm_rsel  <= 1'b0;
            dbus_tcm_rsel  <= 1'b0;
            dbus_gpio_rsel <= 1'b0;
        end else begin
            if (ibus_req) begin
                ibus_tcm_rsel <= ibus_tcm_sel;
            end
            if (dbus_req) begin
                dbus_tcm_rsel  <= dbus_tcm_sel;
                dbus_gpio_rsel <= dbus_gpio_sel;
            end
        end
    end

    assign ibus_rdata = ibus_tcm_rsel ? ibus_tcm_rdata : '0;
    assign dbus_rdata = dbus_tcm_rsel  ? dbus_tcm_rdata  :
                        dbus_gpio_rsel ? dbus_gpio_rdata : '0;

    // responses are held off for good once a fault is latched
    assign ibus_resp = ~fault & ibus_tcm_resp;
    assign dbus_resp = ~fault & (dbus_tcm_resp | dbus_gpio_resp);

    // a response comes back from exactly the target selected at request time
    assert property (@(posedge clk) disable iff (!rstn)
        dbus_resp |-> $onehot({dbus_tcm_rsel, dbus_gpio_rsel}));
    assert property (@(posedge clk) disable iff (!rstn)
        ibus_resp |-> ibus_tcm_rsel);

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import fabric_pkg::*; (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [xlen-1:0]       ibus_addr,
    input  wire acc_e            ibus_acc,
    input  wire                  ibus_req,
    output logic [bus_width-1:0] ibus_rdata,
    output logic                 ibus_resp,
    output logic                 ibus_fault,
    input  wire [xlen-1:0]       dbus_addr,
    input  wire                  dbus_w_rb,
    input  wire acc_e            dbus_acc,
    input  wire [bus_width-1:0]  dbus_wdata,
    input  wire                  dbus_req,
    output logic [bus_width-1:0] dbus_rdata,
    output logic                 dbus_resp,
    output logic                 dbus_fault,
    output logic [xlen-1:0]      tgt_addr,
    output logic                 tgt_w_rb,
    output acc_e                 tgt_acc,
    output logic [bus_width-1:0] tgt_wdata,
    output logic                 tgt_req,
    input  wire [bus_width-1:0]  tgt_rdata,
    input  wire                  tgt_resp,
    input  wire                  tgt_fault
);
    arb_state_e           state, next_state;
    logic                 ibus_ongoing, dbus_ongoing;
    logic [xlen-1:0]      ibus_addr_q, dbus_addr_q;
    acc_e                 ibus_acc_q, dbus_acc_q;
    logic                 dbus_w_rb_q;
    logic [bus_width-1:0] dbus_wdata_q;

    // request fields for an access that has to wait
    always_ff @(posedge clk) begin
        if (ibus_req) begin
            ibus_addr_q <= ibus_addr;
            ibus_acc_q  <= ibus_acc;
        end
        if (dbus_req) begin
            dbus_addr_q  <= dbus_addr;
            dbus_w_rb_q  <= dbus_w_rb;
            dbus_acc_q   <= dbus_acc;
            dbus_wdata_q <= dbus_wdata;
        end
    end

    // access issued or waiting until its resp
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ibus_ongoing <= 1'b0;
            dbus_ongoing <= 1'b0;
            state        <= arb_idle;
        end else begin
            if (ibus_req) begin
                ibus_ongoing <= 1'b1;
            end else if (ibus_resp) begin
                ibus_ongoing <= 1'b0;
            end
            if (dbus_req) begin
                dbus_ongoing <= 1'b1;
            end else if (dbus_resp) begin
                dbus_ongoing <= 1'b0;
            end
            state <= next_state;
        end
    end

    // data bus first and a waiting fetch next
    always_comb begin
        next_state = state;
        case (state)
            arb_ibus: begin
                if (tgt_resp) begin
                    if (dbus_req || dbus_ongoing) begin
                        next_state = arb_dbus;
                    end else if (ibus_req) begin
                        next_state = arb_ibus;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_dbus: begin
                if (tgt_resp) begin
                    if (ibus_req || ibus_ongoing) begin
                        next_state = arb_ibus;
                    end else if (dbus_req) begin
                        next_state = arb_dbus;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            default: begin
                if (dbus_req) begin
                    next_state = arb_dbus;
                end else if (ibus_req) begin
                    next_state = arb_ibus;
                end else begin
                    next_state = arb_idle;
                end
            end
        endcase
    end

    // issue when free or in the cycle the current access completes
    assign tgt_req = (state == arb_idle || tgt_resp) && next_state != arb_idle;

    // live fields in the request cycle and held ones later
    always_comb begin
        if (next_state == arb_ibus) begin
            tgt_addr = ibus_req ? ibus_addr : ibus_addr_q;
            tgt_acc  = ibus_req ? ibus_acc : ibus_acc_q;
            tgt_w_rb = 1'b0;
        end else begin
            tgt_addr = dbus_req ? dbus_addr : dbus_addr_q;
            tgt_acc  = dbus_req ? dbus_acc : dbus_acc_q;
            tgt_w_rb = dbus_req ? dbus_w_rb : dbus_w_rb_q;
        end
    end
    assign tgt_wdata = dbus_req ? dbus_wdata : dbus_wdata_q;

    assign ibus_fault = tgt_req & tgt_fault & (next_state == arb_ibus);
    assign dbus_fault = tgt_req & tgt_fault & (next_state == arb_dbus);
    assign ibus_resp  = tgt_resp & (state == arb_ibus);
    assign dbus_resp  = tgt_resp & (state == arb_dbus);
    assign ibus_rdata = tgt_rdata;
    assign dbus_rdata = tgt_rdata;

    // target only answers an access that was issued by an owner
    assert property (@(posedge clk) disable iff (!rstn) tgt_resp |-> state != arb_idle);
    assert property (@(posedge clk) disable iff (!rstn) !(ibus_resp && dbus_resp));

endmodule

`default_nettype wire

/* logic/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

    localparam int xlen      = 32;
    localparam int bus_width = 32;

    typedef enum logic [1:0] {
        acc_byte = 2'd0,
        acc_half = 2'd1,
        acc_word = 2'd2
    } acc_e;

    // owner of the shared target
    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_ibus = 2'd1,
        arb_dbus = 2'd2
    } arb_state_e;

    typedef enum logic [1:0] {
        fault_none = 2'd0,
        fault_ibus = 2'd1,
        fault_dbus = 2'd2
    } fault_cause_e;

    // address map
    localparam logic [xlen-1:0] tcm_base      = 32'h1000_0000;
    localparam logic [xlen-1:0] tcm_sel_mask  = 32'hFFFF_0000;
    localparam logic [xlen-1:0] gpio_base     = 32'h2000_0000;
    localparam logic [xlen-1:0] gpio_sel_mask = 32'hFFFF_FF00;

    // gpio register offsets
    localparam logic [7:0] gpio_out_off = 8'h00;
    localparam logic [7:0] gpio_dir_off = 8'h04;
    localparam logic [7:0] gpio_in_off  = 8'h08;

endpackage

`default_nettype wire

/* logic/fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_top import fabric_pkg::*; #(
    parameter int tcm_depth  = 1024,
    parameter int gpio_width = 8
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [xlen-1:0]       ibus_addr,
    input  wire acc_e            ibus_acc,
    input  wire                  ibus_req,
    output wire [bus_width-1:0]  ibus_rdata,
    output wire                  ibus_resp,
    input  wire [xlen-1:0]       dbus_addr,
    input  wire                  dbus_w_rb,
    input  wire acc_e            dbus_acc,
    input  wire [bus_width-1:0]  dbus_wdata,
    input  wire                  dbus_req,
    output wire [bus_width-1:0]  dbus_rdata,
    output wire                  dbus_resp,
    input  wire [gpio_width-1:0] gpio_i,
    output wire [gpio_width-1:0] gpio_o,
    output wire [gpio_width-1:0] gpio_dir,
    output wire                  fault,
    output wire fault_cause_e    fault_cause,
    output wire [xlen-1:0]       fault_addr
);
    wire                 ibus_tcm_req, dbus_tcm_req, dbus_gpio_req;
    wire                 ibus_tcm_resp, dbus_tcm_resp, dbus_gpio_resp;
    wire [bus_width-1:0] ibus_tcm_rdata, dbus_tcm_rdata, dbus_gpio_rdata;
    wire                 ibus_dec_fault, dbus_dec_fault;
    wire                 ibus_tgt_fault, dbus_tgt_fault, gpio_fault;

    // shared tcm port
    wire [xlen-1:0]      tgt_addr;
    wire                 tgt_w_rb;
    wire acc_e           tgt_acc;
    wire [bus_width-1:0] tgt_wdata, tgt_rdata;
    wire                 tgt_req, tgt_resp, tgt_fault;

    addr_decoder i_addr_decoder (
        .clk             (clk),
        .rstn            (rstn),
        .ibus_addr       (ibus_addr),
        .ibus_req        (ibus_req),
        .dbus_addr       (dbus_addr),
        .dbus_req        (dbus_req),
        .fault           (fault),
        .ibus_tcm_rdata  (ibus_tcm_rdata),
        .ibus_tcm_resp   (ibus_tcm_resp),
        .dbus_tcm_rdata  (dbus_tcm_rdata),
        .dbus_tcm_resp   (dbus_tcm_resp),
        .dbus_gpio_rdata (dbus_gpio_rdata),
        .dbus_gpio_resp  (dbus_gpio_resp),
        .ibus_tcm_req    (ibus_tcm_req),
        .dbus_tcm_req    (dbus_tcm_req),
        .dbus_gpio_req   (dbus_gpio_req),
        .ibus_rdata      (ibus_rdata),
        .ibus_resp       (ibus_resp),
        .dbus_rdata      (dbus_rdata),
        .dbus_resp       (dbus_resp),
        .ibus_dec_fault  (ibus_dec_fault),
        .dbus_dec_fault  (dbus_dec_fault)
    );

    bus_arbiter i_bus_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .ibus_addr  (ibus_addr),
        .ibus_acc   (ibus_acc),
        .ibus_req   (ibus_tcm_req),
        .ibus_rdata (ibus_tcm_rdata),
        .ibus_resp  (ibus_tcm_resp),
        .ibus_fault (ibus_tgt_fault),
        .dbus_addr  (dbus_addr),
        .dbus_w_rb  (dbus_w_rb),
        .dbus_acc   (dbus_acc),
        .dbus_wdata (dbus_wdata),
        .dbus_req   (dbus_tcm_req),
        .dbus_rdata (dbus_tcm_rdata),
        .dbus_resp  (dbus_tcm_resp),
        .dbus_fault (dbus_tgt_fault),
        .tgt_addr   (tgt_addr),
        .tgt_w_rb   (tgt_w_rb),
        .tgt_acc    (tgt_acc),
        .tgt_wdata  (tgt_wdata),
        .tgt_req    (tgt_req),
        .tgt_rdata  (tgt_rdata),
        .tgt_resp   (tgt_resp),
        .tgt_fault  (tgt_fault)
    );

    tcm_target #(
        .tcm_depth (tcm_depth)
    ) i_tcm_target (
        .clk   (clk),
        .rstn  (rstn),
        .addr  (tgt_addr),
        .w_rb  (tgt_w_rb),
        .acc   (tgt_acc),
        .wdata (tgt_wdata),
        .req   (tgt_req),
        .rdata (tgt_rdata),
        .resp  (tgt_resp),
        .fault (tgt_fault)
    );

    gpio_target #(
        .gpio_width (gpio_width)
    ) i_gpio_target (
        .clk      (clk),
        .rstn     (rstn),
        .addr     (dbus_addr),
        .w_rb     (dbus_w_rb),
        .acc      (dbus_acc),
        .wdata    (dbus_wdata),
        .req      (dbus_gpio_req),
        .rdata    (dbus_gpio_rdata),
        .resp     (dbus_gpio_resp),
        .fault    (gpio_fault),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o),
        .gpio_dir (gpio_dir)
    );

    fault_capture i_fault_capture (
        .clk            (clk),
        .rstn           (rstn),
        .ibus_addr      (ibus_addr),
        .dbus_addr      (dbus_addr),
        .ibus_dec_fault (ibus_dec_fault),
        .dbus_dec_fault (dbus_dec_fault),
        .ibus_tgt_fault (ibus_tgt_fault),
        .dbus_tgt_fault (dbus_tgt_fault),
        .gpio_fault     (gpio_fault),
        .fault          (fault),
        .fault_cause    (fault_cause),
        .fault_addr     (fault_addr)
    );

endmodule

`default_nettype wire

/* logic/fault_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module fault_capture import fabric_pkg::*; (
    input  wire              clk,
    input  wire              rstn,
    input  wire [xlen-1:0]   ibus_addr,
    input  wire [xlen-1:0]   dbus_addr,
    input  wire              ibus_dec_fault,
    input  wire              dbus_dec_fault,
    input  wire              ibus_tgt_fault,
    input  wire              dbus_tgt_fault,
    input  wire              gpio_fault,
    output logic             fault,
    output fault_cause_e     fault_cause,
    output logic [xlen-1:0]  fault_addr
);
    logic ibus_any, dbus_any;

    assign ibus_any = ibus_dec_fault | ibus_tgt_fault;
    assign dbus_any = dbus_dec_fault | dbus_tgt_fault | gpio_fault;

    // first fault wins with the fetch side ahead of the data side
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fault       <= 1'b0;
            fault_cause <= fault_none;
            fault_addr  <= '0;
        end else if (!fault && (ibus_any || dbus_any)) begin
            fault <= 1'b1;
            if (ibus_any) begin
                fault_cause <= fault_ibus;
                fault_addr  <= ibus_addr;
            end else begin
                fault_cause <= fault_dbus;
                fault_addr  <= dbus_addr;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) fault |-> fault_cause != fault_none);

endmodule

`default_nettype wire

/* logic/gpio_target.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_target import fabric_pkg::*; #(
    parameter int gpio_width = 8
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire [xlen-1:0]        addr,
    input  wire                   w_rb,
    input  wire acc_e             acc,
    input  wire [bus_width-1:0]   wdata,
    input  wire                   req,
    output logic [bus_width-1:0]  rdata,
    output logic                  resp,
    output logic                  fault,
    input  wire [gpio_width-1:0]  gpio_i,
    output logic [gpio_width-1:0] gpio_o,
    output logic [gpio_width-1:0] gpio_dir
);
    logic [gpio_width-1:0] gpio_i_meta, gpio_i_sync;
    logic                  ok;

    // aligned words only
    assign fault = req & (acc != acc_word || addr[1:0] != 2'b00);
    assign ok    = req & ~fault;

    // two flop synchronizer
    always_ff @(posedge clk) begin
        gpio_i_meta <= gpio_i;
        gpio_i_sync <= gpio_i_meta;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gpio_o   <= '0;
            gpio_dir <= '0;
            resp     <= 1'b0;
        end else begin
            resp <= ok;
            if (ok && w_rb) begin
                case (addr[7:0])
                    gpio_out_off: gpio_o <= wdata[gpio_width-1:0];
                    gpio_dir_off: gpio_dir <= wdata[gpio_width-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ok) begin
            case (addr[7:0])
                gpio_out_off: rdata <= bus_width'(gpio_o);
                gpio_dir_off: rdata <= bus_width'(gpio_dir);
                gpio_in_off:  rdata <= bus_width'(gpio_i_sync);
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/tcm_target.sv */
`timescale 1ns/1ps
`default_nettype none

module tcm_target import fabric_pkg::*; #(
    parameter int tcm_depth = 1024
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire [xlen-1:0]       addr,
    input  wire                  w_rb,
    input  wire acc_e            acc,
    input  wire [bus_width-1:0]  wdata,
    input  wire                  req,
    output logic [bus_width-1:0] rdata,
    output logic                 resp,
    output logic                 fault
);
    localparam int aw = $clog2(tcm_depth);

    logic [bus_width-1:0] mem [tcm_depth];
    logic [aw-1:0]        idx;
    logic                 misaligned;
    logic                 ok;

    // word index wraps at the depth
    assign idx = addr[aw+1:2];

    always_comb begin
        case (acc)
            acc_byte: misaligned = 1'b0;
            acc_half: misaligned = addr[0];
            acc_word: misaligned = |addr[1:0];
            default:  misaligned = 1'b1;
        endcase
    end

    assign fault = req & misaligned;
    assign ok    = req & ~misaligned;

    // narrow writes take the low bits of wdata
    always_ff @(posedge clk) begin
        if (ok) begin
            if (w_rb) begin
                case (acc)
                    acc_byte: mem[idx][8*addr[1:0] +: 8] <= wdata[7:0];
                    acc_half: mem[idx][16*addr[1] +: 16] <= wdata[15:0];
                    default:  mem[idx] <= wdata;
                endcase
            end
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp <= 1'b0;
        end else begin
            resp <= ok;
        end
    end

endmodule

`default_nettype wire
